// File: rtl/mem_arb_pkg.sv
`default_nettype none

package mem_arb_pkg;

    localparam int num_clients      = 3;
    localparam int client_idx_width = 2;
    localparam int queue_depth      = 4;   // power of two
    localparam int queue_idx_width  = $clog2(queue_depth);
    localparam int addr_width       = 4;
    localparam int mem_words        = 2 ** addr_width;
    localparam int data_width       = 32;
    localparam int tag_width        = 6;
    localparam int mem_latency      = 2;   // busy cycles per request
    localparam int lat_cnt_width    = $clog2(mem_latency + 1);
    localparam int rd_rsvd_width    = data_width - client_idx_width - tag_width;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

    // read view of the payload word
    typedef struct packed {
        logic [client_idx_width-1:0] client;
        logic [tag_width-1:0]        tag;
        logic [rd_rsvd_width-1:0]    reserved;
    } mem_rd_fields_t;

    typedef union packed {
        logic [data_width-1:0] wr_data;
        mem_rd_fields_t        rd;
    } mem_payload_u;

    typedef struct packed {
        mem_op_e                op;
        logic [addr_width-1:0]  addr;
        mem_payload_u           payload;
        logic                   critical;
    } mem_req_t;

    typedef struct packed {
        logic [client_idx_width-1:0] client;
        logic [tag_width-1:0]        tag;
        logic [data_width-1:0]       data;
    } mem_resp_t;

    typedef logic [num_clients-1:0] req_vec_t;

endpackage

`default_nettype wire

// File: rtl/request_queue.sv
`default_nettype none
`timescale 1ns/100ps

module request_queue
    import mem_arb_pkg::*;
(
    input  logic     clk_in,
    input  logic     reset_in,

    input  mem_req_t push_req,
    input  logic     push_valid,
    output logic     accept,

    output mem_req_t head_req,
    output logic     head_valid,
    output logic     full,
    input  logic     pop
);

    mem_req_t entries [queue_depth];

    // extra msb tells a full buffer from an empty one
    logic [queue_idx_width:0] wr_ptr;
    logic [queue_idx_width:0] rd_ptr;
    logic                     empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[queue_idx_width] != rd_ptr[queue_idx_width]) &&
                   (wr_ptr[queue_idx_width-1:0] == rd_ptr[queue_idx_width-1:0]);

    assign accept     = push_valid & ~full;   // same-cycle acceptance pulse
    assign head_valid = ~empty;
    assign head_req   = entries[rd_ptr[queue_idx_width-1:0]];

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            entries[wr_ptr[queue_idx_width-1:0]] <= push_req;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (accept)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // pop on an empty queue is ignored
            if (pop && !empty)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/priority_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module priority_arbiter
    import mem_arb_pkg::*;
(
    input  logic     clk_in,
    input  logic     reset_in,

    input  mem_req_t client_req [num_clients],
    input  req_vec_t client_valid,
    output req_vec_t client_accept,

    output mem_req_t grant_req,
    output logic     grant_valid,
    input  logic     issue_ack
);

    mem_req_t head_req [num_clients];
    req_vec_t head_valid;
    req_vec_t queue_full;
    req_vec_t crit_vec;
    req_vec_t pop;

    logic [client_idx_width-1:0] last_served;
    logic [client_idx_width-1:0] crit_sel;
    logic [client_idx_width-1:0] any_sel;
    logic [client_idx_width-1:0] sel;
    logic                        crit_found;
    logic                        any_found;
    logic                        load_en;

    for (genvar i = 0; i < num_clients; i++)
    begin : g_client
        request_queue request_queue_i
        (
            .clk_in     (clk_in),
            .reset_in   (reset_in),
            .push_req   (client_req[i]),
            .push_valid (client_valid[i]),
            .accept     (client_accept[i]),
            .head_req   (head_req[i]),
            .head_valid (head_valid[i]),
            .full       (queue_full[i]),
            .pop        (pop[i])
        );

        // a full queue only raises the priority of its own head
        assign crit_vec[i] = head_req[i].critical | queue_full[i];

        assign pop[i] = load_en & any_found & (sel == client_idx_width'(i));
    end

    // round robin scan starting after last_served
    always_comb
    begin
        logic [client_idx_width-1:0] cand;
        crit_found = 1'b0;
        any_found  = 1'b0;
        crit_sel   = '0;
        any_sel    = '0;
        for (int k = 1; k <= num_clients; k++)
        begin
            cand = client_idx_width'((int'(last_served) + k) % num_clients);
            if (head_valid[cand] && !any_found)
            begin
                any_found = 1'b1;
                any_sel   = cand;
            end
            if (head_valid[cand] && crit_vec[cand] && !crit_found)
            begin
                crit_found = 1'b1;
                crit_sel   = cand;
            end
        end
    end

    assign sel     = crit_found ? crit_sel : any_sel;   // critical heads first
    assign load_en = ~grant_valid | issue_ack;          // output free or leaving

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            grant_valid <= 1'b0;
            last_served <= '0;
        end
        else if (load_en)
        begin
            grant_valid <= any_found;   // drops when no head is waiting
            if (any_found)
            begin
                last_served <= sel;
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load_en && any_found)
        begin
            grant_req <= head_req[sel];
        end
    end

endmodule

`default_nettype wire

// File: rtl/word_memory_port.sv
`default_nettype none
`timescale 1ns/100ps

module word_memory_port
    import mem_arb_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,

    input  mem_req_t  grant_req,
    input  logic      grant_valid,
    output logic      issue_ack,

    output mem_resp_t resp,
    output logic      resp_valid
);

    logic [data_width-1:0]    mem [mem_words];
    logic                     busy;
    logic [lat_cnt_width-1:0] cnt;
    logic                     ack_write;

    assign ack_write = issue_ack && (grant_req.op == mem_write);

    // idle -> busy for mem_latency cycles -> one ack cycle
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            busy       <= 1'b0;
            cnt        <= '0;
            issue_ack  <= 1'b0;
            resp_valid <= 1'b0;
        end
        else
        begin
            issue_ack  <= 1'b0;
            resp_valid <= issue_ack && (grant_req.op == mem_read);
            if (issue_ack)
            begin
                busy <= 1'b0;
            end
            else if (busy)
            begin
                if (cnt == lat_cnt_width'(mem_latency - 1))
                begin
                    issue_ack <= 1'b1;
                end
                else
                begin
                    cnt <= cnt + 1'b1;
                end
            end
            else if (grant_valid)
            begin
                busy <= 1'b1;
                cnt  <= '0;
            end
        end
    end

    // contents start at zero after reset
    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            for (int i = 0; i < mem_words; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (ack_write)
        begin
            mem[grant_req.addr] <= grant_req.payload.wr_data;
        end
    end

    // read response takes client and tag from the read view
    always_ff @(posedge clk_in)
    begin
        if (issue_ack && !ack_write)
        begin
            resp.client <= grant_req.payload.rd.client;
            resp.tag    <= grant_req.payload.rd.tag;
            resp.data   <= mem[grant_req.addr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_arb_top.sv
`default_nettype none
`timescale 1ns/100ps

module mem_arb_top
    import mem_arb_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset_in,

    input  mem_req_t  req [num_clients],
    input  req_vec_t  req_valid,
    output req_vec_t  req_accept,

    output mem_resp_t resp,
    output logic      resp_valid
);

    mem_req_t grant_req;    // held until issue_ack
    logic     grant_valid;
    logic     issue_ack;

    priority_arbiter priority_arbiter_i
    (
        .clk_in        (clk_in),
        .reset_in      (reset_in),
        .client_req    (req),
        .client_valid  (req_valid),
        .client_accept (req_accept),
        .grant_req     (grant_req),
        .grant_valid   (grant_valid),
        .issue_ack     (issue_ack)
    );

    word_memory_port word_memory_port_i
    (
        .clk_in      (clk_in),
        .reset_in    (reset_in),
        .grant_req   (grant_req),
        .grant_valid (grant_valid),
        .issue_ack   (issue_ack),
        .resp        (resp),
        .resp_valid  (resp_valid)
    );

endmodule

`default_nettype wire

// File: sim/mem_arb_props.sv
`default_nettype none
`timescale 1ns/100ps

module mem_arb_props
    import mem_arb_pkg::*;
(
    input logic     clk_in,
    input logic     reset_in,
    input mem_req_t grant_req,
    input logic     grant_valid,
    input logic     issue_ack,
    input logic     resp_valid
);

    // request held steady until the port takes it
    grant_stable_a: assert property (@(posedge clk_in) disable iff (reset_in)
        grant_valid && !issue_ack |=> grant_valid && $stable(grant_req))
        else $error("grant changed before issue_ack");

    ack_with_grant_a: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack |-> grant_valid)
        else $error("issue_ack without grant_valid");

    read_resp_a: assert property (@(posedge clk_in) disable iff (reset_in)
        issue_ack && grant_req.op == mem_read |=> resp_valid)
        else $error("no resp_valid after read ack");

    resp_source_a: assert property (@(posedge clk_in) disable iff (reset_in)
        resp_valid |-> $past(issue_ack && grant_req.op == mem_read))
        else $error("resp_valid without a read ack");

endmodule

bind word_memory_port mem_arb_props mem_arb_props_i
(
    .clk_in      (clk_in),
    .reset_in    (reset_in),
    .grant_req   (grant_req),
    .grant_valid (grant_valid),
    .issue_ack   (issue_ack),
    .resp_valid  (resp_valid)
);

`default_nettype wire

// File: sim/tb_mem_arb_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_mem_arb_top
    import mem_arb_pkg::*;
();

    logic      clk_in;
    logic      reset_in;
    mem_req_t  req [num_clients];
    req_vec_t  req_valid;
    req_vec_t  req_accept;
    mem_resp_t resp;
    logic      resp_valid;

    integer                seed;
    logic [data_width-1:0] model_mem [mem_words];
    mem_req_t              pend_q [num_clients][$];   // waiting to be accepted
    mem_resp_t             exp_q [num_clients][$];    // accepted reads, in order
    int                    resp_order [$];
    int                    stall_count;

    mem_arb_top mem_arb_top_i
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .req        (req),
        .req_valid  (req_valid),
        .req_accept (req_accept),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    initial
    begin
        clk_in = 1'b0;
        forever
        begin
            #50 clk_in = ~clk_in;
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Regression failed");
        $fatal(1, "run aborted");
    endtask

    // client i owns the addresses whose index mod 3 is i
    function automatic mem_req_t make_req(input int client, input mem_op_e op, input int slot,
                                          input logic [31:0] value, input logic critical);
        mem_req_t r;
        r          = '0;
        r.op       = op;
        r.addr     = addr_width'(client + num_clients * slot);
        r.critical = critical;
        if (op == mem_write)
        begin
            r.payload.wr_data = value;
        end
        else
        begin
            r.payload.rd.client = client_idx_width'(client);
            r.payload.rd.tag    = tag_width'(value);
        end
        return r;
    endfunction

    task automatic random_req(input int client, output mem_req_t r);
        logic [31:0] rnd;
        int          slots;
        int          slot;
        rnd   = $random(seed);
        slots = (mem_words - client + num_clients - 1) / num_clients;
        slot  = int'(rnd[15:8]) % slots;
        r = make_req(client, mem_op_e'(rnd[0]), slot, $random(seed),
                     rnd[1] & rnd[2]);   // roughly one in four critical
    endtask

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < num_clients; i++)
        begin
            n += pend_q[i].size() + exp_q[i].size();
        end
        return n;
    endfunction

    task automatic record_accept(input int client, input mem_req_t r);
        mem_resp_t e;
        if (r.op == mem_write)
        begin
            model_mem[r.addr] = r.payload.wr_data;   // done once accepted
        end
        else
        begin
            e.client = client_idx_width'(client);
            e.tag    = r.payload.rd.tag;
            e.data   = model_mem[r.addr];
            exp_q[client].push_back(e);
        end
    endtask

    task automatic drive_cycle();
        req_vec_t valid_now;
        @(negedge clk_in);
        valid_now = '0;
        for (int i = 0; i < num_clients; i++)
        begin
            if (pend_q[i].size() > 0)
            begin
                req[i]       = pend_q[i][0];
                valid_now[i] = 1'b1;
            end
        end
        req_valid = valid_now;
        #45;   // just before the rising edge
        check_value("req_accept without req_valid", 64'(req_accept & ~valid_now), 64'd0);
        for (int i = 0; i < num_clients; i++)
        begin
            if (valid_now[i] && req_accept[i])
            begin
                record_accept(i, pend_q[i].pop_front());
            end
            else if (valid_now[i])
            begin
                stall_count++;
            end
        end
    endtask

    task automatic send_all();
        int cycles;
        cycles = 0;
        while (pend_q[0].size() + pend_q[1].size() + pend_q[2].size() > 0)
        begin
            if (cycles == 300)
            begin
                abort_run("requests were not accepted within 300 cycles");
            end
            drive_cycle();
            cycles++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        drive_cycle();
        while (pending_count() > 0 || mem_arb_top_i.grant_valid ||
               mem_arb_top_i.priority_arbiter_i.head_valid != '0)
        begin
            if (cycles == 300)
            begin
                abort_run("DUT did not finish its reads within 300 cycles");
            end
            drive_cycle();
            cycles++;
        end
    endtask

    task automatic check_order(input int first, input int count);
        check_value("response count", 64'(resp_order.size()), 64'(count));
        for (int k = 0; k < count; k++)
        begin
            check_value("resp.client order", 64'(resp_order[k]),
                        64'((first + k) % num_clients));
        end
    endtask

    always @(negedge clk_in)
    begin : resp_monitor
        mem_resp_t e;
        int        c;
        c = int'(resp.client);
        if (!reset_in && resp_valid)
        begin
            if (c >= num_clients || exp_q[c].size() == 0)
            begin
                abort_run("read response arrived for a client with no outstanding read");
            end
            else
            begin
                e = exp_q[c].pop_front();
                check_value("resp", 64'(resp), 64'(e));
                resp_order.push_back(c);
            end
        end
    end

    initial
    begin
        logic [31:0] rnd;
        mem_req_t    r;
        seed        = 15956;
        reset_in    = 1'b1;
        req_valid   = '0;
        stall_count = 0;
        for (int i = 0; i < num_clients; i++)
        begin
            req[i] = '0;
        end
        for (int a = 0; a < mem_words; a++)
        begin
            model_mem[a] = '0;
        end
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;
        @(negedge clk_in);
        check_value("resp_valid", 64'(resp_valid), 64'd0);
        check_value("req_accept", 64'(req_accept), 64'd0);

        // every word reads back as zero after reset
        for (int a = 0; a < mem_words; a++)
        begin
            pend_q[a % num_clients].push_back(make_req(a % num_clients, mem_read,
                                                       a / num_clients, a, 1'b0));
        end
        send_all();
        wait_idle();

        for (int n = 0; n < 400; n++)
        begin
            for (int c = 0; c < num_clients; c++)
            begin
                rnd = $random(seed);
                if (pend_q[c].size() == 0 && rnd[0])
                begin
                    random_req(c, r);
                    pend_q[c].push_back(r);
                end
            end
            drive_cycle();
        end
        wait_idle();

        // one client outruns its queue
        stall_count = 0;
        for (int k = 0; k < 8; k++)
        begin
            pend_q[0].push_back(make_req(0, mem_read, k % 6, 40 + k, 1'b0));
        end
        send_all();
        check_value("req_accept stall seen", 64'(stall_count > 0), 64'd1);
        wait_idle();

        // a long write from client 0 holds the port while the others queue up
        pend_q[0].push_back(make_req(0, mem_write, 0, 32'h1234_5678, 1'b0));
        send_all();
        resp_order.delete();
        for (int k = 0; k < 2; k++)
        begin
            for (int c = 0; c < num_clients; c++)
            begin
                pend_q[c].push_back(make_req(c, mem_read, k, 16 + 2 * c + k, 1'b0));
            end
        end
        send_all();
        wait_idle();
        check_order(1, 6);

        // critical head of client 0 jumps ahead of clients 1 and 2
        pend_q[0].push_back(make_req(0, mem_write, 1, 32'hcafe_0003, 1'b0));
        send_all();
        resp_order.delete();
        pend_q[0].push_back(make_req(0, mem_read, 1, 30, 1'b1));
        pend_q[1].push_back(make_req(1, mem_read, 0, 31, 1'b0));
        pend_q[2].push_back(make_req(2, mem_read, 0, 32, 1'b0));
        send_all();
        wait_idle();
        check_order(0, 3);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/mem_arb_pkg.sv
rtl/request_queue.sv
rtl/priority_arbiter.sv
rtl/word_memory_port.sv
rtl/mem_arb_top.sv
sim/mem_arb_props.sv
sim/tb_mem_arb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_mem_arb_top \
    -o tb_mem_arb_top

status=0
./obj_dir/tb_mem_arb_top > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"
